// ==== verif/fdtd_mem_tests.txt ====
# hy_base ez_base words write_seed rounds
# bases and seed in hex, words and rounds in decimal
00000100 00000400 8 1a2b3c4d 1
00000800 00000a00 20 0badf00d 3
00000000 00000040 1 13572468 1
00000c00 00000e00 17 deadbeef 3
00000204 00000604 33 5eed0001 5
00000300 00000380 16 7c0ffee7 2

// ==== fdtd_mem_ctrl.f ====
design/fdtd_mem_pkg.sv
design/fdtd_addr_gen.sv
design/fdtd_sequencer.sv
design/fdtd_wb_master.sv
design/fdtd_mem_ctrl.sv
verif/tb_wb_memory.sv
verif/fdtd_mem_ctrl_properties.sv
verif/tb_fdtd_mem_ctrl.sv

// ==== Bender.yml ====
package:
  name: fdtd_mem_ctrl

sources:
  - design/fdtd_mem_pkg.sv
  - design/fdtd_addr_gen.sv
  - design/fdtd_sequencer.sv
  - design/fdtd_wb_master.sv
  - design/fdtd_mem_ctrl.sv
  - target: test
    files:
      - verif/tb_wb_memory.sv
      - verif/fdtd_mem_ctrl_properties.sv
      - verif/tb_fdtd_mem_ctrl.sv

// ==== verif/tb_fdtd_mem_ctrl.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_fdtd_mem_ctrl
    import fdtd_mem_pkg::*;
();

    localparam int          BUF_WORDS  = 8;
    localparam int          MEM_WORDS  = 1024;
    localparam logic [31:0] SEED       = 32'hfc2e_af92;
    localparam string       TESTS_FILE = "verif/fdtd_mem_tests.txt";

    logic              ACLK;
    logic              ARESETn;
    job_cfg_t          cfg;
    logic              start;
    logic              wr_start;
    logic              irq_clr;
    logic              irq_en;
    logic [DATA_W-1:0] wr_data;
    wb_req_t           wb_req;
    wb_rsp_t           wb_rsp;
    logic              rd_valid;
    rd_beat_t          rd_beat;
    logic              wr_ack;
    logic              busy;
    logic              buffer_rdy;
    logic              irq_pending;
    logic              irq;

    logic [31:0]       rng_state;
    int                mismatch_cnt;
    int                other_cnt;
    int                cycle_cnt;
    int                cycle_limit;
    logic              write_ok;

    // jobs from the tests file
    job_cfg_t          job_q [$];
    logic [31:0]       seed_q [$];
    int                rounds_q [$];

    // expected traffic of the running job
    rd_beat_t          beat_q [$];
    logic [DATA_W-1:0] wr_queue [$];
    logic [DATA_W-1:0] exp_mem [MEM_WORDS];

    fdtd_mem_ctrl #(
        .BUF_WORDS     ( BUF_WORDS   )
    ) i_dut (
        .ACLK          ( ACLK        ),
        .ARESETn       ( ARESETn     ),
        .cfg_i         ( cfg         ),
        .start_i       ( start       ),
        .wr_start_i    ( wr_start    ),
        .irq_clr_i     ( irq_clr     ),
        .irq_en_i      ( irq_en      ),
        .wr_data_i     ( wr_data     ),
        .wb_i          ( wb_rsp      ),
        .wb_o          ( wb_req      ),
        .rd_valid_o    ( rd_valid    ),
        .rd_beat_o     ( rd_beat     ),
        .wr_ack_o      ( wr_ack      ),
        .busy_o        ( busy        ),
        .buffer_rdy_o  ( buffer_rdy  ),
        .irq_pending_o ( irq_pending ),
        .irq_o         ( irq         )
    );

    tb_wb_memory #(
        .MEM_WORDS ( MEM_WORDS ),
        .SEED      ( SEED      )
    ) i_mem (
        .ACLK      ( ACLK      ),
        .ARESETn   ( ARESETn   ),
        .wb_i      ( wb_req    ),
        .wb_o      ( wb_rsp    )
    );

    initial
    begin
        ACLK = 1'b0;
        forever #20 ACLK = ~ACLK;
    end

    //////////////////////////////////////////////////
    // helpers and compare tasks
    //////////////////////////////////////////////////
    function automatic logic [31:0] next_rand();
        rng_state = rng_state * 32'd1664525 + 32'd1013904223;
        return rng_state;
    endfunction

    task automatic after_edge();
        @(posedge ACLK);
        #2;
    endtask

    task automatic check_beat(input string what, input rd_beat_t got, input rd_beat_t exp);
        if (got !== exp)
        begin
            mismatch_cnt++;
            $display("MISMATCH at %0t: %s got field %0d data %08h, expected field %0d data %08h",
                     $time, what, got.field, got.data, exp.field, exp.data);
        end
    endtask

    task automatic check_word(input string what, input logic [DATA_W-1:0] got,
                              input logic [DATA_W-1:0] exp);
        if (got !== exp)
        begin
            mismatch_cnt++;
            $display("MISMATCH at %0t: %s got %08h, expected %08h", $time, what, got, exp);
        end
    endtask

    task automatic check_flag(input string what, input logic got, input logic exp);
        if (got !== exp)
        begin
            mismatch_cnt++;
            $display("MISMATCH at %0t: %s got %b, expected %b", $time, what, got, exp);
        end
    endtask

    // preload memory, draw write words, build expected beats and writes
    task automatic prepare_job(input job_cfg_t job, input logic [31:0] seed);
        int                hy_idx;
        int                ez_idx;
        int                words;
        int                off;
        int                len;
        logic [DATA_W-1:0] word;
        logic [DATA_W-1:0] hy_wr [$];
        logic [DATA_W-1:0] ez_wr [$];
        rd_beat_t          beat;
        rng_state = seed;
        for (int i = 0; i < MEM_WORDS; i++)
        begin
            word = next_rand() ^ (32'(i) << 2);
            exp_mem[i] = word;
            i_mem.mem[i] <= word;
        end
        hy_idx = int'(job.hy_base[ADDR_W-1:2]);
        ez_idx = int'(job.ez_base[ADDR_W-1:2]);
        words  = int'(job.words);
        for (int k = 0; k < words; k++)
        begin
            hy_wr.push_back(next_rand());
            ez_wr.push_back(next_rand());
        end
        beat_q.delete();
        wr_queue.delete();
        off = 0;
        while (off < words)
        begin
            len = ((words - off) < BUF_WORDS) ? (words - off) : BUF_WORDS;
            for (int j = 0; j < len; j++)
            begin
                beat.field = FIELD_HY;
                beat.data  = exp_mem[hy_idx + off + j];
                beat_q.push_back(beat);
            end
            for (int j = 0; j < len; j++)
            begin
                beat.field = FIELD_EZ;
                beat.data  = exp_mem[ez_idx + off + j];
                beat_q.push_back(beat);
            end
            for (int j = 0; j < len; j++)
                wr_queue.push_back(hy_wr[off + j]);
            for (int j = 0; j < len; j++)
                wr_queue.push_back(ez_wr[off + j]);
            off += len;
        end
        for (int k = 0; k < words; k++)
        begin
            exp_mem[hy_idx + k] = hy_wr[k];
            exp_mem[ez_idx + k] = ez_wr[k];
        end
    endtask

    //////////////////////////////////////////////////
    // one job from start to interrupt clear
    //////////////////////////////////////////////////
    task automatic run_job(input job_cfg_t job, input int exp_rounds, input int idx);
        job_cfg_t other;
        int       rounds;
        logic     rdy_prev;
        other.hy_base = job.ez_base;
        other.ez_base = job.hy_base;
        other.words   = job.words + 16'd3;
        rounds   = 0;
        rdy_prev = 1'b0;
        write_ok = 1'b0;
        wr_data  = wr_queue[0];
        irq_en   = idx[0];

        after_edge();
        cfg   = job;
        start = 1'b1;
        after_edge();
        start = 1'b0;
        check_flag("busy after start", busy, 1'b1);
        // a second job while busy must be ignored
        cfg   = other;
        start = 1'b1;
        after_edge();
        start = 1'b0;
        // early write start while the buffer is not ready
        if (!buffer_rdy)
        begin
            wr_start = 1'b1;
            after_edge();
            wr_start = 1'b0;
        end

        while (busy)
        begin
            @(negedge ACLK);
            if (buffer_rdy && !rdy_prev)
            begin
                rounds++;
                write_ok = 1'b0;
                repeat (3)
                begin
                    @(negedge ACLK);
                    check_flag("buffer ready held until write start", buffer_rdy, 1'b1);
                end
                after_edge();
                wr_start = 1'b1;
                write_ok = 1'b1;
                after_edge();
                wr_start = 1'b0;
            end
            rdy_prev = buffer_rdy;
        end

        // pending follows one cycle behind the busy fall
        check_flag("irq pending as busy falls", irq_pending, 1'b0);
        @(negedge ACLK);
        check_flag("irq pending after busy falls", irq_pending, 1'b1);
        check_flag("irq with enable", irq, irq_en);
        after_edge();
        irq_en = !irq_en;
        @(negedge ACLK);
        check_flag("irq after enable toggle", irq, irq_en);
        after_edge();
        irq_clr = 1'b1;
        after_edge();
        irq_clr = 1'b0;
        check_flag("irq pending after clear", irq_pending, 1'b0);
        check_flag("irq after clear", irq, 1'b0);
        cfg = job;

        check_word("round count", DATA_W'(rounds), DATA_W'(exp_rounds));
        if (beat_q.size() != 0)
        begin
            other_cnt++;
            $display("job %0d ended with %0d read beats missing", idx, beat_q.size());
        end
        if (wr_queue.size() != 0)
        begin
            other_cnt++;
            $display("job %0d ended with %0d words never written", idx, wr_queue.size());
        end
        for (int i = 0; i < MEM_WORDS; i++)
            check_word($sformatf("memory at %08h", i * 4), i_mem.mem[i], exp_mem[i]);
    endtask

    //////////////////////////////////////////////////
    // monitors
    //////////////////////////////////////////////////
    always @(negedge ACLK)
    begin
        if (ARESETn && rd_valid)
        begin
            if (beat_q.size() == 0)
            begin
                other_cnt++;
                $display("read beat at %0t arrived with none expected", $time);
            end
            else
                check_beat("read beat", rd_beat, beat_q.pop_front());
        end
    end

    // supply the next write word after each ack
    always @(negedge ACLK)
    begin
        if (ARESETn && wr_ack)
        begin
            if (wr_queue.size() == 0)
            begin
                other_cnt++;
                $display("write ack at %0t with no write word left", $time);
            end
            else
            begin
                check_word("write data on bus", wb_req.dat, wr_queue.pop_front());
                after_edge();
                if (wr_queue.size() != 0)
                    wr_data = wr_queue[0];
            end
        end
    end

    always @(negedge ACLK)
    begin
        if (ARESETn && wb_req.cyc && wb_req.we && !write_ok)
        begin
            other_cnt++;
            $display("write cycle at %0t before a write start was accepted", $time);
        end
    end

    always @(posedge ACLK)
    begin
        cycle_cnt++;
        if ((cycle_limit != 0) && (cycle_cnt > cycle_limit))
        begin
            $display("timeout after %0d cycles, the run did not finish", cycle_cnt);
            $display("** FAIL **");
            $finish;
        end
    end

    //////////////////////////////////////////////////
    // main sequence
    //////////////////////////////////////////////////
    initial
    begin
        int          fd;
        int          n;
        string       line;
        job_cfg_t    job;
        logic [31:0] hy;
        logic [31:0] ez;
        logic [31:0] seed;
        int          words;
        int          rounds;
        ARESETn      = 1'b0;
        cfg          = '0;
        start        = 1'b0;
        wr_start     = 1'b0;
        irq_clr      = 1'b0;
        irq_en       = 1'b0;
        wr_data      = '0;
        mismatch_cnt = 0;
        other_cnt    = 0;
        cycle_cnt    = 0;
        cycle_limit  = 0;
        write_ok     = 1'b0;
        rng_state    = SEED;

        fd = $fopen(TESTS_FILE, "r");
        if (fd == 0)
        begin
            $display("cannot open tests file %s", TESTS_FILE);
            $display("** FAIL **");
            $finish;
        end
        else
        begin
            while (!$feof(fd))
            begin
                line = "";
                void'($fgets(line, fd));
                // skip comment and blank lines
                if ((line.len() > 1) && (line.getc(0) != 8'h23))
                begin
                    n = $sscanf(line, "%h %h %d %h %d", hy, ez, words, seed, rounds);
                    if (n == 5)
                    begin
                        job.hy_base = hy;
                        job.ez_base = ez;
                        job.words   = SIZE_W'(words);
                        job_q.push_back(job);
                        seed_q.push_back(seed);
                        rounds_q.push_back(rounds);
                        cycle_limit += 40 * words + 200;
                    end
                end
            end
            $fclose(fd);
            cycle_limit += 20;
            if (job_q.size() == 0)
            begin
                other_cnt++;
                $display("tests file holds no jobs");
            end

            repeat (5) @(posedge ACLK);
            @(negedge ACLK);
            check_flag("busy in reset", busy, 1'b0);
            check_flag("buffer ready in reset", buffer_rdy, 1'b0);
            check_flag("irq pending in reset", irq_pending, 1'b0);
            check_flag("irq in reset", irq, 1'b0);
            check_flag("read valid in reset", rd_valid, 1'b0);
            check_flag("write ack in reset", wr_ack, 1'b0);
            check_flag("cyc in reset", wb_req.cyc, 1'b0);
            check_flag("stb in reset", wb_req.stb, 1'b0);
            repeat (5) @(posedge ACLK);
            #2;
            ARESETn = 1'b1;

            for (int t = 0; t < job_q.size(); t++)
            begin
                prepare_job(job_q[t], seed_q[t]);
                run_job(job_q[t], rounds_q[t], t);
            end

            $display("jobs %0d, mismatches %0d, other errors %0d, assertion failures %0d",
                     job_q.size(), mismatch_cnt, other_cnt, i_dut.i_properties.fail_cnt);
            if ((mismatch_cnt == 0) && (other_cnt == 0) && (i_dut.i_properties.fail_cnt == 0))
                $display("** PASS **");
            else
                $display("** FAIL **");
            $finish;
        end
    end

endmodule

`default_nettype wire

// ==== verif/fdtd_mem_ctrl_properties.sv ====
`timescale 1ns/1ps
`default_nettype none

module fdtd_mem_ctrl_properties
    import fdtd_mem_pkg::*;
(
    input wire logic    ACLK,
    input wire logic    ARESETn,
    input wire wb_req_t wb_o,
    input wire wb_rsp_t wb_i,
    input wire logic    busy_o,
    input wire logic    buffer_rdy_o,
    input wire logic    irq_pending_o,
    input wire logic    irq_o
);

    // failed assertion count
    int fail_cnt = 0;

    stb_in_cyc: assert property (@(posedge ACLK) disable iff (!ARESETn)
        wb_o.stb |-> wb_o.cyc)
        else
        begin
            fail_cnt++;
            $error("wishbone stb high without cyc");
        end

    // request held until the slave acks
    req_stable: assert property (@(posedge ACLK) disable iff (!ARESETn)
        (wb_o.stb && !wb_i.ack) |=>
            (wb_o.stb && $stable(wb_o.adr) && $stable(wb_o.we) && $stable(wb_o.dat)))
        else
        begin
            fail_cnt++;
            $error("wishbone request changed before ack");
        end

    idle_after_reset: assert property (@(posedge ACLK)
        $rose(ARESETn) |-> (!busy_o && !buffer_rdy_o))
        else
        begin
            fail_cnt++;
            $error("busy or buffer ready high out of reset");
        end

    irq_needs_pending: assert property (@(posedge ACLK) disable iff (!ARESETn)
        irq_o |-> irq_pending_o)
        else
        begin
            fail_cnt++;
            $error("irq high without a pending interrupt");
        end

endmodule

bind fdtd_mem_ctrl fdtd_mem_ctrl_properties i_properties (
    .ACLK          ( ACLK          ),
    .ARESETn       ( ARESETn       ),
    .wb_o          ( wb_o          ),
    .wb_i          ( wb_i          ),
    .busy_o        ( busy_o        ),
    .buffer_rdy_o  ( buffer_rdy_o  ),
    .irq_pending_o ( irq_pending_o ),
    .irq_o         ( irq_o         )
);

`default_nettype wire

// ==== verif/tb_wb_memory.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_wb_memory
    import fdtd_mem_pkg::*;
#(
    parameter int          MEM_WORDS = 1024,
    parameter logic [31:0] SEED      = 32'hfc2e_af92
)
(
    input  wire logic    ACLK,
    input  wire logic    ARESETn,
    input  wire wb_req_t wb_i,
    output wb_rsp_t      wb_o
);

    localparam int IDX_W = $clog2(MEM_WORDS);

    logic [DATA_W-1:0] mem [MEM_WORDS];
    logic [31:0]       rng_q;
    logic [1:0]        wait_q;
    logic              ack_q;
    logic [DATA_W-1:0] rdat_q;
    logic [IDX_W-1:0]  idx;

    function automatic logic [31:0] step_lcg(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    // word index with the upper address bits wrapping
    assign idx = wb_i.adr[IDX_W+1:2];

    always @(posedge ACLK or negedge ARESETn)
    begin
        if (!ARESETn)
        begin
            ack_q  <= 1'b0;
            wait_q <= 2'd0;
            rng_q  <= SEED;
        end
        else if (ack_q)
        begin
            // draw 0 to 3 wait states for the next access
            ack_q  <= 1'b0;
            rng_q  <= step_lcg(rng_q);
            wait_q <= rng_q[31:30];
        end
        else if (wb_i.cyc && wb_i.stb)
        begin
            if (wait_q != 2'd0)
                wait_q <= wait_q - 2'd1;
            else
            begin
                ack_q  <= 1'b1;
                rdat_q <= mem[idx];
                // only the selected byte lanes are written
                if (wb_i.we)
                begin
                    for (int b = 0; b < 4; b++)
                        if (wb_i.sel[b])
                            mem[idx][8*b +: 8] <= wb_i.dat[8*b +: 8];
                end
            end
        end
    end

    assign wb_o.ack = ack_q;
    assign wb_o.dat = rdat_q;

endmodule

`default_nettype wire

// ==== design/fdtd_mem_ctrl.sv ====
`timescale 1ns/1ps
`default_nettype none

module fdtd_mem_ctrl
    import fdtd_mem_pkg::*;
#(
    parameter int BUF_WORDS = 8
)
(
    input  wire logic              ACLK,
    input  wire logic              ARESETn,

    // job and control
    input  wire job_cfg_t          cfg_i,
    input  wire logic              start_i,
    input  wire logic              wr_start_i,
    input  wire logic              irq_clr_i,
    input  wire logic              irq_en_i,
    input  wire logic [DATA_W-1:0] wr_data_i,

    // memory port
    input  wire wb_rsp_t           wb_i,
    output wb_req_t                wb_o,

    // compute side and status
    output logic                   rd_valid_o,
    output rd_beat_t               rd_beat_o,
    output logic                   wr_ack_o,
    output logic                   busy_o,
    output logic                   buffer_rdy_o,
    output logic                   irq_pending_o,
    output logic                   irq_o
);

    logic              load;
    logic              req;
    logic              step;
    logic              gnt;
    access_t           access;
    logic [ADDR_W-1:0] word_adr;

    //////////////////////////////////////////////////
    // round control
    //////////////////////////////////////////////////
    fdtd_sequencer #(
        .BUF_WORDS     ( BUF_WORDS     )
    ) i_sequencer (
        .ACLK          ( ACLK          ),
        .ARESETn       ( ARESETn       ),
        .cfg_words_i   ( cfg_i.words   ),
        .start_i       ( start_i       ),
        .wr_start_i    ( wr_start_i    ),
        .gnt_i         ( gnt           ),
        .irq_clr_i     ( irq_clr_i     ),
        .irq_en_i      ( irq_en_i      ),
        .load_o        ( load          ),
        .req_o         ( req           ),
        .step_o        ( step          ),
        .access_o      ( access        ),
        .busy_o        ( busy_o        ),
        .buffer_rdy_o  ( buffer_rdy_o  ),
        .irq_pending_o ( irq_pending_o ),
        .irq_o         ( irq_o         )
    );

    fdtd_addr_gen i_addr_gen (
        .ACLK       ( ACLK     ),
        .ARESETn    ( ARESETn  ),
        .cfg_i      ( cfg_i    ),
        .load_i     ( load     ),
        .step_i     ( step     ),
        .access_i   ( access   ),
        .word_adr_o ( word_adr )
    );

    //////////////////////////////////////////////////
    // bus access
    //////////////////////////////////////////////////
    fdtd_wb_master i_wb_master (
        .ACLK       ( ACLK         ),
        .ARESETn    ( ARESETn      ),
        .req_i      ( req          ),
        .we_i       ( access.we    ),
        .adr_i      ( word_adr     ),
        .wdata_i    ( wr_data_i    ),
        .field_i    ( access.field ),
        .wb_i       ( wb_i         ),
        .wb_o       ( wb_o         ),
        .gnt_o      ( gnt          ),
        .rd_valid_o ( rd_valid_o   ),
        .rd_beat_o  ( rd_beat_o    ),
        .wr_ack_o   ( wr_ack_o     )
    );

endmodule

`default_nettype wire

// ==== design/fdtd_wb_master.sv ====
`timescale 1ns/1ps
`default_nettype none

module fdtd_wb_master
    import fdtd_mem_pkg::*;
(
    input  wire logic              ACLK,
    input  wire logic              ARESETn,

    input  wire logic              req_i,
    input  wire logic              we_i,
    input  wire logic [ADDR_W-1:0] adr_i,
    input  wire logic [DATA_W-1:0] wdata_i,
    input  wire field_e            field_i,

    input  wire wb_rsp_t           wb_i,
    output wb_req_t                wb_o,

    output logic                   gnt_o,
    output logic                   rd_valid_o,
    output rd_beat_t               rd_beat_o,
    output logic                   wr_ack_o
);

    logic              cyc_q;
    logic              we_q;
    logic [ADDR_W-1:0] adr_q;
    logic [DATA_W-1:0] dat_q;
    logic              rd_valid_q;
    rd_beat_t          beat_q;
    logic              ack;
    logic              launch;

    assign ack    = cyc_q && wb_i.ack;
    // one access at a time, next one starts after cyc drops
    assign launch = req_i && !cyc_q;

    //////////////////////////////////////////////////
    // classic cycle
    //////////////////////////////////////////////////
    always_ff @(posedge ACLK, negedge ARESETn)
    begin
        if (!ARESETn)
            cyc_q <= 1'b0;
        else if (launch)
            cyc_q <= 1'b1;
        else if (ack)
            cyc_q <= 1'b0;
    end

    // address, direction and write word held for the whole cycle
    always_ff @(posedge ACLK)
    begin
        if (launch)
        begin
            we_q  <= we_i;
            adr_q <= adr_i;
            dat_q <= wdata_i;
        end
    end

    assign wb_o.cyc = cyc_q;
    assign wb_o.stb = cyc_q;
    assign wb_o.we  = we_q;
    assign wb_o.sel = '1;
    assign wb_o.adr = adr_q;
    assign wb_o.dat = dat_q;

    // read beat registered at ack
    always_ff @(posedge ACLK)
    begin
        if (ack && !we_q)
        begin
            beat_q.field <= field_i;
            beat_q.data  <= wb_i.dat;
        end
    end

    always_ff @(posedge ACLK, negedge ARESETn)
    begin
        if (!ARESETn)
            rd_valid_q <= 1'b0;
        else
            rd_valid_q <= ack && !we_q;
    end

    assign gnt_o      = ack;
    assign wr_ack_o   = ack && we_q;
    assign rd_valid_o = rd_valid_q;
    assign rd_beat_o  = beat_q;

endmodule

`default_nettype wire

// ==== design/fdtd_sequencer.sv ====
`timescale 1ns/1ps
`default_nettype none

module fdtd_sequencer
    import fdtd_mem_pkg::*;
#(
    parameter int BUF_WORDS = 8
)
(
    input  wire logic              ACLK,
    input  wire logic              ARESETn,

    input  wire logic [SIZE_W-1:0] cfg_words_i,
    input  wire logic              start_i,
    input  wire logic              wr_start_i,
    input  wire logic              gnt_i,
    input  wire logic              irq_clr_i,
    input  wire logic              irq_en_i,

    output logic                   load_o,
    output logic                   req_o,
    output logic                   step_o,
    output access_t                access_o,

    output logic                   busy_o,
    output logic                   buffer_rdy_o,
    output logic                   irq_pending_o,
    output logic                   irq_o
);

    localparam logic [SIZE_W-1:0] BUF_LEN = SIZE_W'(BUF_WORDS);

    seq_state_e        state_q;
    seq_state_e        state_d;
    logic [SIZE_W-1:0] rem_q;
    logic [SIZE_W-1:0] cnt_q;
    logic [SIZE_W-1:0] chunk_len;
    logic              chunk_last;
    logic              start_ok;
    logic              busy_q;
    logic              irq_pending_q;

    // a job with no words is never started
    assign start_ok   = (state_q == IDLE) && start_i && (cfg_words_i != '0);

    // short last chunk when fewer than BUF_WORDS remain
    assign chunk_len  = (rem_q < BUF_LEN) ? rem_q : BUF_LEN;
    assign chunk_last = gnt_i && (cnt_q == chunk_len - 1'b1);

    //////////////////////////////////////////////////
    // round state machine
    //////////////////////////////////////////////////
    always_comb
    begin
        state_d = state_q;
        case (state_q)
            IDLE:
                if (start_ok)
                    state_d = READ_HY;
            READ_HY:
                if (chunk_last)
                    state_d = READ_EZ;
            READ_EZ:
                if (chunk_last)
                    state_d = WAIT_CALC;
            WAIT_CALC:
                if (wr_start_i)
                    state_d = WRITE_HY;
            WRITE_HY:
                if (chunk_last)
                    state_d = WRITE_EZ;
            WRITE_EZ:
                if (chunk_last)
                begin
                    // last chunk of the job ends the round in idle
                    if (rem_q == chunk_len)
                        state_d = IDLE;
                    else
                        state_d = READ_HY;
                end
            default:
                state_d = IDLE;
        endcase
    end

    always_ff @(posedge ACLK, negedge ARESETn)
    begin
        if (!ARESETn)
            state_q <= IDLE;
        else
            state_q <= state_d;
    end

    // word count inside chunk, words left in job
    always_ff @(posedge ACLK, negedge ARESETn)
    begin
        if (!ARESETn)
        begin
            cnt_q <= '0;
            rem_q <= '0;
        end
        else
        begin
            if (start_ok)
                rem_q <= cfg_words_i;
            else if ((state_q == WRITE_EZ) && chunk_last)
                rem_q <= rem_q - chunk_len;

            if (chunk_last)
                cnt_q <= '0;
            else if (gnt_i)
                cnt_q <= cnt_q + 1'b1;
        end
    end

    // access kind follows the state
    always_comb
    begin
        if ((state_q == READ_EZ) || (state_q == WRITE_EZ))
            access_o.field = FIELD_EZ;
        else
            access_o.field = FIELD_HY;
        access_o.we = (state_q == WRITE_HY) || (state_q == WRITE_EZ);
    end

    assign req_o  = (state_q == READ_HY) || (state_q == READ_EZ) ||
                    (state_q == WRITE_HY) || (state_q == WRITE_EZ);
    assign step_o = req_o && gnt_i;
    assign load_o = start_ok;

    //////////////////////////////////////////////////
    // status and interrupt
    //////////////////////////////////////////////////
    assign busy_o       = (state_q != IDLE);
    assign buffer_rdy_o = (state_q == WAIT_CALC);

    always_ff @(posedge ACLK, negedge ARESETn)
    begin
        if (!ARESETn)
        begin
            busy_q        <= 1'b0;
            irq_pending_q <= 1'b0;
        end
        else
        begin
            busy_q <= busy_o;
            // clear has priority over a job finishing
            if (irq_clr_i)
                irq_pending_q <= 1'b0;
            else if (busy_q && !busy_o)
                irq_pending_q <= 1'b1;
        end
    end

    assign irq_pending_o = irq_pending_q;
    assign irq_o         = irq_en_i && irq_pending_q;

endmodule

`default_nettype wire

// ==== design/fdtd_addr_gen.sv ====
`timescale 1ns/1ps
`default_nettype none

module fdtd_addr_gen
    import fdtd_mem_pkg::*;
(
    input  wire logic      ACLK,
    input  wire logic      ARESETn,

    input  wire job_cfg_t  cfg_i,
    input  wire logic      load_i,
    input  wire logic      step_i,
    input  wire access_t   access_i,

    output logic [ADDR_W-1:0] word_adr_o
);

    localparam int PTR_W = ADDR_W - 2;

    // pointer slots, indexed by {we, field}
    localparam logic [1:0] RD_HY = 2'd0;
    localparam logic [1:0] RD_EZ = 2'd1;
    localparam logic [1:0] WR_HY = 2'd2;
    localparam logic [1:0] WR_EZ = 2'd3;

    logic [PTR_W-1:0] ptr_q [4];
    logic [1:0]       sel;

    assign sel = {access_i.we, access_i.field};

    //////////////////////////////////////////////////
    // word pointers
    //////////////////////////////////////////////////
    always_ff @(posedge ACLK, negedge ARESETn)
    begin
        if (!ARESETn)
        begin
            for (int i = 0; i < 4; i++)
                ptr_q[i] <= '0;
        end
        else if (load_i)
        begin
            // read and write walk the same region
            ptr_q[RD_HY] <= cfg_i.hy_base[ADDR_W-1:2];
            ptr_q[RD_EZ] <= cfg_i.ez_base[ADDR_W-1:2];
            ptr_q[WR_HY] <= cfg_i.hy_base[ADDR_W-1:2];
            ptr_q[WR_EZ] <= cfg_i.ez_base[ADDR_W-1:2];
        end
        else if (step_i)
        begin
            ptr_q[sel] <= ptr_q[sel] + 1'b1;
        end
    end

    // back to a byte address
    assign word_adr_o = {ptr_q[sel], 2'b00};

endmodule

`default_nettype wire

// ==== design/fdtd_mem_pkg.sv ====
`default_nettype none

package fdtd_mem_pkg;

    // bus and job widths
    localparam int ADDR_W = 32;
    localparam int DATA_W = 32;
    localparam int SIZE_W = 16;

    // field tag carried with every access
    typedef enum logic {
        FIELD_HY,
        FIELD_EZ
    } field_e;

    // round sequencer states
    typedef enum logic [2:0] {
        IDLE,
        READ_HY,
        READ_EZ,
        WAIT_CALC,
        WRITE_HY,
        WRITE_EZ
    } seq_state_e;

    // job as loaded by start
    typedef struct packed {
        logic [ADDR_W-1:0] hy_base;
        logic [ADDR_W-1:0] ez_base;
        logic [SIZE_W-1:0] words;
    } job_cfg_t;

    // wishbone classic master side
    typedef struct packed {
        logic              cyc;
        logic              stb;
        logic              we;
        logic [3:0]        sel;
        logic [ADDR_W-1:0] adr;
        logic [DATA_W-1:0] dat;
    } wb_req_t;

    // wishbone classic slave side
    typedef struct packed {
        logic              ack;
        logic [DATA_W-1:0] dat;
    } wb_rsp_t;

    // one word on the read stream
    typedef struct packed {
        field_e            field;
        logic [DATA_W-1:0] data;
    } rd_beat_t;

    // kind of the access in progress
    typedef struct packed {
        field_e field;
        logic   we;
    } access_t;

endpackage

`default_nettype wire
